/* hdl/mf2_pkg.sv */
// Multiface Two shared widths, port codes, shadow RAM map and gate-array command view
package mf2_pkg;

	// Bus widths
	localparam int CPU_AW = 16;
	localparam int DATA_W = 8;
	localparam int MF2_AW = 13;  // 8 KB cartridge RAM

	// Cartridge mode codes
	localparam logic [1:0] MODE_ENABLED  = 2'd0;
	localparam logic [1:0] MODE_HIDDEN   = 2'd1;
	localparam logic [1:0] MODE_DISABLED = 2'd2;

	// High address byte of the shadowed write-only ports
	localparam logic [DATA_W-1:0] PORT_GA       = 8'h7F;
	localparam logic [DATA_W-1:0] PORT_CRTC_SEL = 8'hBC;
	localparam logic [DATA_W-1:0] PORT_CRTC_VAL = 8'hBD;
	localparam logic [DATA_W-1:0] PORT_PPI      = 8'hF7;
	localparam logic [DATA_W-1:0] PORT_UROM     = 8'hDF;

	// FEE8 / FEEA share everything above bit 1
	localparam logic [CPU_AW-3:0] PAGE_PORT_HI = 14'b11111110111010;
	localparam logic [CPU_AW-1:0] NMI_VECTOR   = 16'h0066;
	localparam logic [CPU_AW-1:0] HIDE_VECTOR  = 16'h0065;

	// Shadow locations at the top of cartridge RAM
	localparam logic [MF2_AW-1:0] SH_PEN_IDX   = 13'h1FCF;
	localparam logic [MF2_AW-1:0] SH_BORDER    = 13'h1FDF;
	localparam logic [MF2_AW-1:0] SH_PEN_BASE  = 13'h1F90;  // + pen number
	localparam logic [MF2_AW-1:0] SH_MODE      = 13'h1FEF;
	localparam logic [MF2_AW-1:0] SH_BANK      = 13'h1FFF;
	localparam logic [MF2_AW-1:0] SH_CRTC_SEL  = 13'h1CFF;
	localparam logic [MF2_AW-1:0] SH_CRTC_BASE = 13'h1DB0;  // + register number
	localparam logic [MF2_AW-1:0] SH_PPI       = 13'h17FF;
	localparam logic [MF2_AW-1:0] SH_UROM      = 13'h1AAC;

	// Gate-array function field
	localparam logic [1:0] GA_FN_PEN    = 2'd0;
	localparam logic [1:0] GA_FN_COLOUR = 2'd1;
	localparam logic [1:0] GA_FN_MODE   = 2'd2;
	localparam logic [1:0] GA_FN_BANK   = 2'd3;

	// Byte written to port 7F, stored raw or decoded by function
	typedef union packed {
		logic [DATA_W-1:0] raw;
		struct packed {
			logic [1:0] func;
			logic [5:0] payload;
		} cmd;
	} ga_cmd_t;

endpackage

/* hdl/mf2_store_decode.sv */
// Multiface Two store decoder, maps hardware register writes onto shadow RAM addresses
`timescale 1ns/100ps

module mf2_store_decode (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      io_wr_rise,
	input  logic [mf2_pkg::CPU_AW-1:0] cpu_addr,
	input  mf2_pkg::ga_cmd_t          cpu_dout,
	output logic [mf2_pkg::MF2_AW-1:0] store_addr
);
	import mf2_pkg::*;

	logic [DATA_W-1:0] port_hi;
	logic [4:0]        pen_idx;   // Bit 4 picks the border
	logic [3:0]        crtc_reg;
	logic              pen_wr;
	logic              crtc_wr;

	// Ports decode on the high address byte only
	assign port_hi = cpu_addr[CPU_AW-1 -: DATA_W];

	assign pen_wr  = io_wr_rise & (port_hi == PORT_GA) & (cpu_dout.cmd.func == GA_FN_PEN);
	assign crtc_wr = io_wr_rise & (port_hi == PORT_CRTC_SEL);

	////////////////////////////////////////
	// Pen index and CRTC register number
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pen_idx  <= '0;
			crtc_reg <= '0;
		end else begin
			if (pen_wr)
				pen_idx <= cpu_dout.raw[4:0];
			if (crtc_wr)
				crtc_reg <= cpu_dout.raw[3:0];
		end
	end

	////////////////////////////////////////
	// Shadow address decode
	////////////////////////////////////////

	// Zero means the write is not shadowed
	always_comb begin
		store_addr = '0;
		case (port_hi)
			PORT_GA: begin
				case (cpu_dout.cmd.func)
					GA_FN_PEN:
						store_addr = SH_PEN_IDX;
					GA_FN_COLOUR: begin
						if (pen_idx[4])
							store_addr = SH_BORDER;
						else
							store_addr = SH_PEN_BASE + MF2_AW'(pen_idx[3:0]);
					end
					GA_FN_MODE:
						store_addr = SH_MODE;   // Screen mode and ROM enables
					GA_FN_BANK:
						store_addr = SH_BANK;   // RAM banking
					default:
						store_addr = '0;
				endcase
			end
			PORT_CRTC_SEL:
				store_addr = SH_CRTC_SEL;
			PORT_CRTC_VAL:
				store_addr = SH_CRTC_BASE + MF2_AW'(crtc_reg);  // One byte per register
			PORT_PPI:
				store_addr = SH_PPI;  // 8255 control
			PORT_UROM:
				store_addr = SH_UROM;
			default:
				store_addr = '0;
		endcase
	end

endmodule

/* hdl/mf2_control.sv */
// Multiface Two controller, NMI request, paging state and cartridge RAM port arbitration
`timescale 1ns/100ps

module mf2_control (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic [1:0]                 mode,
	input  logic [mf2_pkg::CPU_AW-1:0] cpu_addr,
	input  logic [mf2_pkg::DATA_W-1:0] cpu_dout,
	input  logic                       m1,
	input  logic                       io_wr,
	input  logic                       mem_wr,
	input  logic                       key_nmi,
	input  logic [mf2_pkg::MF2_AW-1:0] store_addr,
	output logic                       io_wr_rise,
	output logic                       nmi,
	output logic                       rom_sel,
	output logic                       ram_sel,
	output logic [mf2_pkg::MF2_AW-1:0] ram_addr,
	output logic [mf2_pkg::DATA_W-1:0] ram_din,
	output logic                       ram_we
);
	import mf2_pkg::*;

	logic m1_q;
	logic io_wr_q;
	logic key_q;
	logic m1_rise;
	logic key_rise;
	logic enable;   // Cartridge paged in
	logic hidden;   // Paging ports ignored
	logic page_hit;
	logic store_hit;
	logic win_wr;

	////////////////////////////////////////
	// Edge detection
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			m1_q    <= 1'b0;
			io_wr_q <= 1'b0;
			key_q   <= 1'b0;
		end else begin
			m1_q    <= m1;
			io_wr_q <= io_wr;
			key_q   <= key_nmi;
		end
	end

	assign m1_rise    = m1 & ~m1_q;
	assign io_wr_rise = io_wr & ~io_wr_q;
	assign key_rise   = key_nmi & ~key_q;

	// FEE8 pages in, FEEA pages out
	assign page_hit  = io_wr_rise & (cpu_addr[CPU_AW-1:2] == PAGE_PORT_HI);
	assign store_hit = io_wr_rise & (|store_addr);

	// ROM in the first 8 KB, RAM in the second
	assign rom_sel = enable & (cpu_addr[CPU_AW-1:MF2_AW] == 3'd0);
	assign ram_sel = enable & (cpu_addr[CPU_AW-1:MF2_AW] == 3'd1);
	assign win_wr  = mem_wr & ram_sel;

	////////////////////////////////////////
	// NMI and paging state
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nmi    <= 1'b0;
			enable <= 1'b0;
			hidden <= (mode != MODE_ENABLED);
		end else begin
			if (key_rise & ~enable & (mode != MODE_DISABLED))
				nmi <= 1'b1;
			// NMI vector fetch pages the cartridge in
			if (m1_rise & nmi & (cpu_addr == NMI_VECTOR)) begin
				enable <= 1'b1;
				hidden <= 1'b0;
				nmi    <= 1'b0;
			end
			if (m1_rise & enable & (cpu_addr == HIDE_VECTOR))
				hidden <= 1'b1;
			if (page_hit)
				enable <= ~cpu_addr[1] & ~hidden & (mode != MODE_DISABLED);
		end
	end

	////////////////////////////////////////
	// RAM port
	////////////////////////////////////////

	// Paging write first, then shadow store, then windowed write
	always_ff @(posedge clk_sys) begin
		if (reset)
			ram_we <= 1'b0;
		else
			ram_we <= ~page_hit & (store_hit | win_wr);
	end

	always_ff @(posedge clk_sys) begin
		ram_addr <= (store_hit & ~page_hit) ? store_addr : cpu_addr[MF2_AW-1:0];
		ram_din  <= cpu_dout;  // Same byte for stores and CPU writes
	end

endmodule

/* hdl/mf2_shadow_ram.sv */
// Multiface Two 8 KB cartridge RAM with registered read and read-bus default
`timescale 1ns/100ps

module mf2_shadow_ram (
	input  logic                       clk_sys,
	input  logic [mf2_pkg::MF2_AW-1:0] ram_addr,
	input  logic [mf2_pkg::DATA_W-1:0] ram_din,
	input  logic                       ram_we,
	input  logic                       ram_sel,
	input  logic                       mem_rd,
	output logic [mf2_pkg::DATA_W-1:0] dout
);
	import mf2_pkg::*;

	localparam int DEPTH = 2 ** MF2_AW;

	logic [DATA_W-1:0] mem [DEPTH];
	logic [DATA_W-1:0] rd_q;

	////////////////////////////////////////
	// Array and read register
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_addr] <= ram_din;
			rd_q          <= ram_din;  // Write data shows on the output
		end else begin
			rd_q <= mem[ram_addr];
		end
	end

	// Undriven bus reads as all ones
	assign dout = (ram_sel & mem_rd) ? rd_q : '1;

endmodule

/* hdl/mf2_top.sv */
// Multiface Two freezer cartridge top level
`timescale 1ns/100ps

module mf2_top (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic [1:0]                 mode,
	input  logic [mf2_pkg::CPU_AW-1:0] cpu_addr,
	input  logic [mf2_pkg::DATA_W-1:0] cpu_dout,
	input  logic                       m1,
	input  logic                       io_wr,
	input  logic                       mem_rd,
	input  logic                       mem_wr,
	input  logic                       key_nmi,
	output logic                       nmi,
	output logic                       rom_sel,
	output logic                       ram_sel,
	output logic [mf2_pkg::DATA_W-1:0] dout
);
	import mf2_pkg::*;

	logic              io_wr_rise;
	logic [MF2_AW-1:0] store_addr;
	logic [MF2_AW-1:0] ram_addr;
	logic [DATA_W-1:0] ram_din;
	logic              ram_we;

	mf2_store_decode u_store_decode (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.io_wr_rise (io_wr_rise),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.store_addr (store_addr)
	);

	mf2_control u_control (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mode       (mode),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.m1         (m1),
		.io_wr      (io_wr),
		.mem_wr     (mem_wr),
		.key_nmi    (key_nmi),
		.store_addr (store_addr),
		.io_wr_rise (io_wr_rise),
		.nmi        (nmi),
		.rom_sel    (rom_sel),
		.ram_sel    (ram_sel),
		.ram_addr   (ram_addr),
		.ram_din    (ram_din),
		.ram_we     (ram_we)
	);

	mf2_shadow_ram u_shadow_ram (
		.clk_sys  (clk_sys),
		.ram_addr (ram_addr),
		.ram_din  (ram_din),
		.ram_we   (ram_we),
		.ram_sel  (ram_sel),
		.mem_rd   (mem_rd),
		.dout     (dout)
	);

endmodule

/* dv/mf2_checker.sv */
// Multiface Two checker, NMI release, select exclusivity and RAM write sources
`timescale 1ns/100ps

module mf2_checker (
	input logic                       clk_sys,
	input logic                       reset,
	input logic                       nmi,
	input logic                       m1,
	input logic                       rom_sel,
	input logic                       ram_sel,
	input logic                       io_wr_rise,
	input logic                       ram_we,
	input logic [mf2_pkg::MF2_AW-1:0] store_addr
);

	int fail_count = 0;  // Read by the testbench at the end

	// nmi drops only on the clock after an m1 rise
	assert property (@(posedge clk_sys) disable iff (reset)
		$fell(nmi) |-> ($past(m1) && !$past(m1, 2)))
	else begin
		fail_count++;
		$error("nmi fell without an m1 rising edge");
	end

	// ROM and RAM halves of the cartridge never both selected
	assert property (@(posedge clk_sys) disable iff (reset)
		!(rom_sel && ram_sel))
	else begin
		fail_count++;
		$error("rom_sel and ram_sel high together");
	end

	////////////////////////////////////////
	// RAM write sources
	////////////////////////////////////////

	// Without a shadow store only a paged-in window write may reach RAM
	assert property (@(posedge clk_sys) disable iff (reset)
		(!ram_sel && !(io_wr_rise && store_addr != '0)) |=> !ram_we)
	else begin
		fail_count++;
		$error("ram_we high while the cartridge is paged out");
	end

endmodule

bind mf2_top mf2_checker u_mf2_checker (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.nmi        (nmi),
	.m1         (m1),
	.rom_sel    (rom_sel),
	.ram_sel    (ram_sel),
	.io_wr_rise (io_wr_rise),
	.ram_we     (ram_we),
	.store_addr (store_addr)
);

/* dv/mf2_tb.sv */
// Multiface Two testbench, reference model for freeze, shadow stores, paging and RAM access
`timescale 1ns/100ps

module mf2_tb;
	import mf2_pkg::*;

	localparam logic [31:0] LFSR_SEED = 32'haff9421b;
	localparam int RST_CYC   = 10;
	localparam int N_GA      = 24;
	localparam int N_PORT    = 16;
	localparam int N_RAM     = 16;
	localparam int NMI_LIMIT = 16;
	localparam int IO_CYC    = 4;
	localparam int RD_CYC    = 4;
	localparam int WR_CYC    = 2;
	localparam int FRZ_CYC   = NMI_LIMIT + 10;
	// Sum of the test lengths plus margin
	localparam int WD_CYC = RST_CYC + (FRZ_CYC + 4) + N_GA * (IO_CYC + RD_CYC)
		+ N_PORT * (IO_CYC + RD_CYC) + (WR_CYC + 4 * (IO_CYC + RD_CYC) + 4)
		+ (FRZ_CYC + 2 * IO_CYC + 2 * N_RAM * (WR_CYC + RD_CYC))
		+ (RST_CYC + 8 + IO_CYC + RD_CYC) + 200;

	logic              clk_sys = 1'b0;
	logic              reset;
	logic [1:0]        mode;
	logic [CPU_AW-1:0] cpu_addr;
	logic [DATA_W-1:0] cpu_dout;
	logic              m1;
	logic              io_wr;
	logic              mem_rd;
	logic              mem_wr;
	logic              key_nmi;
	logic              nmi;
	logic              rom_sel;
	logic              ram_sel;
	logic [DATA_W-1:0] dout;

	// Reference model state
	logic [DATA_W-1:0] ref_mem [2 ** MF2_AW];
	logic [4:0]        m_pen;
	logic [3:0]        m_crtc;
	logic [31:0]       lfsr_state = LFSR_SEED;

	// Handoff to the compare process
	logic              chk_en;
	logic [DATA_W-1:0] exp_byte;
	logic [MF2_AW-1:0] chk_addr;
	string             test_name;
	int                n_checks;
	int                n_errors;
	int                n_tests;
	int                n_bad_tests;
	int                errs_at_start;

	mf2_top u_mf2_top (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mode     (mode),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.m1       (m1),
		.io_wr    (io_wr),
		.mem_rd   (mem_rd),
		.mem_wr   (mem_wr),
		.key_nmi  (key_nmi),
		.nmi      (nmi),
		.rom_sel  (rom_sel),
		.ram_sel  (ram_sel),
		.dout     (dout)
	);

	always #20 clk_sys = ~clk_sys;

	////////////////////////////////////////
	// Random source and reference model
	////////////////////////////////////////

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);  // One step per bit
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [MF2_AW-1:0] ref_store_addr(input logic [DATA_W-1:0] port,
			input ga_cmd_t cmd);
		logic [MF2_AW-1:0] a;
		a = '0;  // Not shadowed
		if (port == PORT_GA) begin
			case (cmd.cmd.func)
				GA_FN_PEN:    a = SH_PEN_IDX;
				GA_FN_COLOUR: a = m_pen[4] ? SH_BORDER : (SH_PEN_BASE + {9'b0, m_pen[3:0]});
				GA_FN_MODE:   a = SH_MODE;
				default:      a = SH_BANK;
			endcase
		end else if (port == PORT_CRTC_SEL) begin
			a = SH_CRTC_SEL;
		end else if (port == PORT_CRTC_VAL) begin
			a = SH_CRTC_BASE + {9'b0, m_crtc};
		end else if (port == PORT_PPI) begin
			a = SH_PPI;
		end else if (port == PORT_UROM) begin
			a = SH_UROM;
		end
		return a;
	endfunction

	// Compare process, dout is stable at the falling edge
	always @(negedge clk_sys) begin
		if (chk_en) begin
			n_checks++;
			assert (dout === exp_byte)
			else begin
				$display("[FAIL] %s at %04h: expected %02h, actual %02h",
					test_name, chk_addr, exp_byte, dout);
				n_errors++;
			end
		end
	end

	////////////////////////////////////////
	// Bookkeeping
	////////////////////////////////////////

	task automatic begin_test(input string name);
		test_name     = name;
		errs_at_start = n_errors;
		n_tests++;
	endtask

	task automatic end_test();
		if (n_errors == errs_at_start) begin
			$display("result %s: ok", test_name);
		end else begin
			$display("result %s: %0d errors", test_name, n_errors - errs_at_start);
			n_bad_tests++;
		end
	endtask

	task automatic check_level(input string what, input logic exp, input logic act);
		n_checks++;
		assert (act === exp)
		else begin
			$display("[FAIL] %s %s: expected %0b, actual %0b", test_name, what, exp, act);
			n_errors++;
		end
	endtask

	////////////////////////////////////////
	// Bus operations
	////////////////////////////////////////

	task automatic apply_reset();
		@(posedge clk_sys);
		reset <= 1'b1;
		repeat (RST_CYC) @(posedge clk_sys);
		reset <= 1'b0;
		m_pen  = '0;
		m_crtc = '0;
	endtask

	task automatic io_write(input logic [CPU_AW-1:0] addr, input logic [DATA_W-1:0] data,
			output logic [MF2_AW-1:0] sa);
		ga_cmd_t cmd;
		cmd = data;
		sa  = ref_store_addr(addr[CPU_AW-1 -: DATA_W], cmd);
		if (sa != '0)
			ref_mem[sa] = data;
		// Pen and register number apply from the next write on
		if (addr[CPU_AW-1 -: DATA_W] == PORT_GA && cmd.cmd.func == GA_FN_PEN)
			m_pen = cmd.raw[4:0];
		if (addr[CPU_AW-1 -: DATA_W] == PORT_CRTC_SEL)
			m_crtc = cmd.raw[3:0];
		@(posedge clk_sys);
		cpu_addr <= addr;
		cpu_dout <= data;
		io_wr    <= 1'b1;
		repeat (IO_CYC - 1) @(posedge clk_sys);
		io_wr <= 1'b0;
	endtask

	task automatic mem_write(input logic [MF2_AW-1:0] addr, input logic [DATA_W-1:0] data,
			input logic taken);
		if (taken)
			ref_mem[addr] = data;
		@(posedge clk_sys);
		cpu_addr <= {3'b001, addr};  // 0x2000 window
		cpu_dout <= data;
		mem_wr   <= 1'b1;
		@(posedge clk_sys);
		mem_wr <= 1'b0;
	endtask

	task automatic read_check(input logic [MF2_AW-1:0] addr, input logic [DATA_W-1:0] exp);
		@(posedge clk_sys);
		cpu_addr <= {3'b001, addr};
		mem_rd   <= 1'b1;
		repeat (2) @(posedge clk_sys);  // Registered address, then registered data
		exp_byte <= exp;
		chk_addr <= addr;
		chk_en   <= 1'b1;
		@(posedge clk_sys);
		chk_en <= 1'b0;
		mem_rd <= 1'b0;
	endtask

	task automatic fetch(input logic [CPU_AW-1:0] addr);
		@(posedge clk_sys);
		cpu_addr <= addr;
		m1       <= 1'b1;
		repeat (3) @(posedge clk_sys);
		m1 <= 1'b0;
	endtask

	task automatic wait_for_nmi();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (nmi !== 1'b1 && n < NMI_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		assert (nmi === 1'b1)
		else begin
			$display("%s: nmi did not rise within %0d clocks of the freeze key",
				test_name, NMI_LIMIT);
			n_errors++;
		end
	endtask

	// Freeze key, then the NMI vector fetch pages the cartridge in
	task automatic freeze_and_enter();
		@(posedge clk_sys);
		key_nmi <= 1'b1;
		wait_for_nmi();
		@(posedge clk_sys);
		key_nmi <= 1'b0;
		fetch(NMI_VECTOR);
		@(negedge clk_sys);
		check_level("nmi after vector fetch", 1'b0, nmi);
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic freeze_entry();
		logic [MF2_AW-1:0] a;
		begin_test("freeze");
		@(negedge clk_sys);
		check_level("rom_sel before freeze", 1'b0, rom_sel);
		freeze_and_enter();
		a = MF2_AW'(rand_bits(MF2_AW));
		@(posedge clk_sys);
		cpu_addr <= {3'b000, a};
		@(negedge clk_sys);
		check_level("rom_sel in ROM window", 1'b1, rom_sel);
		check_level("ram_sel in ROM window", 1'b0, ram_sel);
		end_test();
	endtask

	task automatic ga_shadowing();
		ga_cmd_t           cmd;
		logic [MF2_AW-1:0] sa;
		begin_test("ga_shadow");
		for (int i = 0; i < N_GA; i++) begin
			cmd.cmd.func    = {1'b0, 1'(rand_bits(1))};  // Pen select or colour
			cmd.cmd.payload = 6'(rand_bits(6));
			io_write({PORT_GA, 8'h00}, cmd.raw, sa);
			read_check(sa, ref_mem[sa]);
		end
		end_test();
	endtask

	task automatic port_shadowing();
		logic [1:0]        k;
		logic [DATA_W-1:0] p;
		logic [MF2_AW-1:0] sa;
		begin_test("port_shadow");
		for (int i = 0; i < N_PORT; i++) begin
			k = (i < 4) ? 2'(i) : 2'(rand_bits(2));  // Each port once, then random
			case (k)
				2'd0:    p = PORT_CRTC_SEL;
				2'd1:    p = PORT_CRTC_VAL;
				2'd2:    p = PORT_PPI;
				default: p = PORT_UROM;
			endcase
			io_write({p, 8'h00}, 8'(rand_bits(8)), sa);
			read_check(sa, ref_mem[sa]);
		end
		end_test();
	endtask

	task automatic paging_ports();
		logic [MF2_AW-1:0] a;
		logic [MF2_AW-1:0] sa;
		begin_test("paging");
		a = MF2_AW'(rand_bits(MF2_AW));
		mem_write(a, 8'(rand_bits(8)), 1'b1);
		io_write(16'hFEE8, 8'h00, sa);
		read_check(a, ref_mem[a]);
		io_write(16'hFEEA, 8'h00, sa);
		read_check(a, 8'hFF);
		io_write(16'hFEE8, 8'h00, sa);
		read_check(a, ref_mem[a]);
		fetch(HIDE_VECTOR);
		io_write(16'hFEE8, 8'h00, sa);  // Hidden, stays paged out
		read_check(a, 8'hFF);
		end_test();
	endtask

	task automatic window_ram();
		logic [MF2_AW-1:0] addrs [N_RAM];
		logic [MF2_AW-1:0] sa;
		begin_test("ram");
		freeze_and_enter();
		for (int i = 0; i < N_RAM; i++) begin
			addrs[i] = MF2_AW'(rand_bits(MF2_AW));
			mem_write(addrs[i], 8'(rand_bits(8)), 1'b1);
		end
		for (int i = 0; i < N_RAM; i++)
			read_check(addrs[i], ref_mem[addrs[i]]);
		io_write(16'hFEEA, 8'h00, sa);
		for (int i = 0; i < N_RAM; i++)
			mem_write(addrs[i], 8'(rand_bits(8)), 1'b0);  // Paged out, dropped
		io_write(16'hFEE8, 8'h00, sa);
		for (int i = 0; i < N_RAM; i++)
			read_check(addrs[i], ref_mem[addrs[i]]);
		end_test();
	endtask

	task automatic disabled_mode();
		logic [MF2_AW-1:0] sa;
		begin_test("disabled");
		@(posedge clk_sys);
		mode <= MODE_DISABLED;
		apply_reset();
		@(posedge clk_sys);
		key_nmi <= 1'b1;
		repeat (4) @(posedge clk_sys);
		key_nmi <= 1'b0;
		@(negedge clk_sys);
		check_level("nmi in disabled mode", 1'b0, nmi);
		io_write(16'hFEE8, 8'h00, sa);
		read_check(MF2_AW'(rand_bits(MF2_AW)), 8'hFF);
		end_test();
	endtask

	initial begin
		reset    <= 1'b1;
		mode     <= MODE_ENABLED;
		cpu_addr <= '0;
		cpu_dout <= '0;
		m1       <= 1'b0;
		io_wr    <= 1'b0;
		mem_rd   <= 1'b0;
		mem_wr   <= 1'b0;
		key_nmi  <= 1'b0;
		chk_en   <= 1'b0;
		exp_byte <= '0;
		chk_addr <= '0;
		n_checks    = 0;
		n_errors    = 0;
		n_tests     = 0;
		n_bad_tests = 0;
		m_pen       = '0;
		m_crtc      = '0;
		repeat (RST_CYC) @(posedge clk_sys);
		reset <= 1'b0;

		freeze_entry();
		ga_shadowing();
		port_shadowing();
		paging_ports();
		window_ram();
		disabled_mode();

		repeat (2) @(posedge clk_sys);
		$display("summary: %0d tests, %0d with errors, %0d checks, %0d errors, %0d assertion hits",
			n_tests, n_bad_tests, n_checks, n_errors, u_mf2_top.u_mf2_checker.fail_count);
		if (n_errors == 0 && u_mf2_top.u_mf2_checker.fail_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WD_CYC) @(posedge clk_sys);
		$display("Watchdog expired, the run did not finish within %0d clocks", WD_CYC);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* mf2_shadow.f */
hdl/mf2_pkg.sv
hdl/mf2_store_decode.sv
hdl/mf2_control.sv
hdl/mf2_shadow_ram.sv
hdl/mf2_top.sv
dv/mf2_checker.sv
dv/mf2_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the Multiface Two testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f mf2_shadow.f --top-module mf2_tb \
	-Mdir "$OBJ_DIR" -o mf2_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ_DIR/mf2_sim" +verilator+error+limit+1000 > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TEST FAILED" "$SIM_LOG"; then
	exit 1
fi
exit 0
